/* vertex_job_control.f */
rtl/vertex_job_pkg.sv
rtl/sync_fifo.sv
rtl/credit_sender.sv
rtl/vertex_read_request.sv
rtl/vertex_chunk_unpack.sv
rtl/vertex_job_control.sv
verification/tb_clock_gen.sv
verification/vertex_job_control_sva.sv
verification/vertex_job_control_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the Verilator model of vertex_job_control_tb, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	--top-module vertex_job_control_tb -f vertex_job_control.f \
	-o vertex_job_control_sim \
	&& ./obj_dir/vertex_job_control_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0

/* verification/vertex_job_control_tb.sv */
// vertex_job_control_tb: job stimulus, memory responder, vertex consumer, reference model, checks

module vertex_job_control_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CMD_CREDITS    = 2;
	localparam int VERTEX_CREDITS = 4;
	localparam int CHUNK          = vertex_job_pkg::CHUNK_VERTICES;
	localparam int VB             = vertex_job_pkg::VERTEX_BITS;
	localparam int NUM_JOBS       = 12;
	localparam int SEED           = 50739;
	localparam int DRAIN_CYCLES   = 40;

	logic                          clock;
	logic                          rstn;
	logic                          job_start;
	vertex_job_pkg::job_desc_t     job;
	logic                          read_command_valid;
	vertex_job_pkg::read_command_t read_command;
	logic                          read_command_credit;
	logic                          read_data_valid;
	vertex_job_pkg::read_data_t    read_data;
	logic                          vertex_valid;
	vertex_job_pkg::vertex_job_t   vertex;
	logic                          vertex_credit;

	// expected traffic, oldest first
	vertex_job_pkg::read_command_t exp_cmd[$];
	vertex_job_pkg::vertex_job_t   exp_vertex[$];
	// commands waiting in the memory model
	vertex_job_pkg::read_command_t mem_cmd[$];
	int                            mem_ready[$];
	int cycle = 0;
	int cmd_owed = 0;
	int vertex_owed = 0;
	int stall_left = 0;
	int errors = 0;
	int cmd_seen = 0;
	int vertex_seen = 0;
	int total_vertices = 0;
	int watchdog_cycles = 0;

	tb_clock_gen #(.PERIOD_NS(40)) u_clock_gen (.clock(clock));

	vertex_job_control #(
		.CMD_FIFO_DEPTH(4),
		.JOB_FIFO_DEPTH(16),
		.CMD_CREDITS   (CMD_CREDITS),
		.VERTEX_CREDITS(VERTEX_CREDITS)
	) u_dut (
		.clock              (clock),
		.rstn               (rstn),
		.job_start          (job_start),
		.job                (job),
		.read_command_valid (read_command_valid),
		.read_command       (read_command),
		.read_command_credit(read_command_credit),
		.read_data_valid    (read_data_valid),
		.read_data          (read_data),
		.vertex_valid       (vertex_valid),
		.vertex             (vertex),
		.vertex_credit      (vertex_credit)
	);

	//////////////////////////////////////////////////
	// memory contents and reference model
	//////////////////////////////////////////////////

	// memory word at a byte address of one array
	function automatic logic [31:0] lane_value(input logic [1:0] arr, input logic [47:0] addr);
		logic [31:0] mix;
		mix = (addr[31:0] * 32'h9e37_79b1) ^ {addr[47:32], addr[15:0]};
		return mix ^ {arr, 30'h2bd5_93c1};
	endfunction

	function automatic logic [vertex_job_pkg::LINE_BITS-1:0] data_line(input logic [1:0] arr,
		input logic [47:0] addr);
		logic [vertex_job_pkg::LINE_BITS-1:0] line;
		for (int j = 0; j < CHUNK; j++) begin
			line[j*VB +: VB] = lane_value(arr, addr + 48'(4 * j));
		end
		return line;
	endfunction

	task automatic add_job_model(input vertex_job_pkg::job_desc_t d);
		logic [47:0]                   base[3];
		logic [47:0]                   chunk_addr;
		int                            n;
		int                            start;
		int                            cnt;
		vertex_job_pkg::read_command_t c;
		vertex_job_pkg::vertex_job_t   v;
		base[0] = d.inv_out_degree_base;
		base[1] = d.inv_edges_idx_base;
		base[2] = d.parent_base;
		n = int'(d.num_vertices);
		start = 0;
		while (start < n) begin
			cnt = ((n - start) > CHUNK) ? CHUNK : (n - start);
			chunk_addr = 48'((start / CHUNK) * vertex_job_pkg::CHUNK_BYTES);
			for (int a = 0; a < 3; a++) begin
				c.address = base[a] + chunk_addr;
				c.array_sel = vertex_job_pkg::array_sel_t'(a);
				c.count = vertex_job_pkg::CHUNK_COUNT_BITS'(cnt);
				exp_cmd.push_back(c);
			end
			for (int i = 0; i < cnt; i++) begin
				v.id = d.first_id + 32'(start + i);
				v.inv_out_degree = lane_value(2'd0, base[0] + chunk_addr + 48'(4 * i));
				v.inv_edges_idx = lane_value(2'd1, base[1] + chunk_addr + 48'(4 * i));
				v.parent = lane_value(2'd2, base[2] + chunk_addr + 48'(4 * i));
				exp_vertex.push_back(v);
			end
			start += CHUNK;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		$display("Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
		errors++;
	endtask

	function automatic logic [47:0] random_base();
		return {16'($urandom), $urandom} & ~48'h3;
	endfunction

	//////////////////////////////////////////////////
	// memory responder, consumer and output checks
	//////////////////////////////////////////////////

	always @(posedge clock) begin : bus_models
		vertex_job_pkg::read_command_t c;
		vertex_job_pkg::vertex_job_t   e;
		vertex_job_pkg::read_data_t    beat;
		int                            ready_n;
		int                            pick;
		int                            idx;
		cycle = cycle + 1;
		// long stretches with every credit held back
		if (stall_left > 0) begin
			stall_left--;
		end else if (($urandom % 64) == 0) begin
			stall_left = 16 + ($urandom % 48);
		end

		if (read_command_valid) begin
			cmd_seen++;
			if (exp_cmd.size() == 0) begin
				$display("read command to 0x%0h arrived when none was expected",
					read_command.address);
				errors++;
			end else begin
				c = exp_cmd.pop_front();
				if (read_command.address !== c.address) begin
					report_mismatch("read_command.address", 64'(read_command.address),
						64'(c.address));
				end
				if (read_command.array_sel !== c.array_sel) begin
					report_mismatch("read_command.array_sel", 64'(read_command.array_sel),
						64'(c.array_sel));
				end
				if (read_command.count !== c.count) begin
					report_mismatch("read_command.count", 64'(read_command.count),
						64'(c.count));
				end
			end
			mem_cmd.push_back(read_command);
			mem_ready.push_back(cycle + 1 + int'($urandom % 8));
			cmd_owed++;
		end

		read_command_credit <= 1'b0;
		if ((cmd_owed > 0) && (stall_left == 0) && (($urandom % 3) == 0)) begin
			read_command_credit <= 1'b1;
			cmd_owed--;
		end

		// answer a random one among the commands whose delay is over
		read_data_valid <= 1'b0;
		ready_n = 0;
		foreach (mem_ready[k]) begin
			if (mem_ready[k] <= cycle) begin
				ready_n++;
			end
		end
		if (ready_n > 0) begin
			pick = int'($urandom % ready_n);
			idx = 0;
			for (int k = 0; k < mem_ready.size(); k++) begin
				if (mem_ready[k] <= cycle) begin
					if (pick == 0) begin
						idx = k;
					end
					pick = pick - 1;
				end
			end
			beat.array_sel = mem_cmd[idx].array_sel;
			beat.data = data_line(mem_cmd[idx].array_sel, mem_cmd[idx].address);
			read_data <= beat;
			read_data_valid <= 1'b1;
			mem_cmd.delete(idx);
			mem_ready.delete(idx);
		end

		if (vertex_valid) begin
			vertex_seen++;
			vertex_owed++;
			if (exp_vertex.size() == 0) begin
				$display("vertex job with id 0x%0h arrived when none was expected", vertex.id);
				errors++;
			end else begin
				e = exp_vertex.pop_front();
				if (vertex.id !== e.id) begin
					report_mismatch("vertex.id", 64'(vertex.id), 64'(e.id));
				end
				if (vertex.inv_out_degree !== e.inv_out_degree) begin
					report_mismatch("vertex.inv_out_degree", 64'(vertex.inv_out_degree),
						64'(e.inv_out_degree));
				end
				if (vertex.inv_edges_idx !== e.inv_edges_idx) begin
					report_mismatch("vertex.inv_edges_idx", 64'(vertex.inv_edges_idx),
						64'(e.inv_edges_idx));
				end
				if (vertex.parent !== e.parent) begin
					report_mismatch("vertex.parent", 64'(vertex.parent), 64'(e.parent));
				end
			end
		end

		vertex_credit <= 1'b0;
		if ((vertex_owed > 0) && (stall_left == 0) && (($urandom % 2) == 0)) begin
			vertex_credit <= 1'b1;
			vertex_owed--;
		end
	end

	//////////////////////////////////////////////////
	// job sequence
	//////////////////////////////////////////////////

	initial begin : main
		int                        sizes[NUM_JOBS];
		int                        assert_fails;
		vertex_job_pkg::job_desc_t desc;
		rstn = 1'b0;
		job_start = 1'b0;
		job = '0;
		read_command_credit = 1'b0;
		read_data_valid = 1'b0;
		read_data = '0;
		vertex_credit = 1'b0;
		void'($urandom(SEED));

		// edge sizes first, two empty jobs in the mix
		sizes[0] = 1;
		sizes[1] = CHUNK;
		sizes[2] = CHUNK + 1;
		sizes[3] = 0;
		for (int j = 4; j < NUM_JOBS; j++) begin
			sizes[j] = (j == 7) ? 0 : int'($urandom_range(70, 1));
		end
		foreach (sizes[j]) begin
			total_vertices += sizes[j];
		end
		watchdog_cycles = total_vertices * 40 + NUM_JOBS * (DRAIN_CYCLES + 100) + 500;

		repeat (3) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);

		for (int j = 0; j < NUM_JOBS; j++) begin
			desc.inv_out_degree_base = random_base();
			desc.inv_edges_idx_base = random_base();
			desc.parent_base = random_base();
			desc.num_vertices = 32'(sizes[j]);
			desc.first_id = $urandom;
			add_job_model(desc);
			job <= desc;
			job_start <= 1'b1;
			@(posedge clock);
			job_start <= 1'b0;
			while ((exp_cmd.size() != 0) || (exp_vertex.size() != 0)) begin
				@(posedge clock);
			end
			// an empty job gets time to show any stray output
			repeat ((sizes[j] == 0) ? 20 : 1 + int'($urandom % 4)) @(posedge clock);
		end
		repeat (DRAIN_CYCLES) @(posedge clock);

		if (vertex_seen != total_vertices) begin
			$display("received %0d vertex jobs but %0d were expected", vertex_seen,
				total_vertices);
			errors++;
		end
		assert_fails = int'(u_dut.u_sva.reset_fails + u_dut.u_sva.cmd_credit_fails
			+ u_dut.u_sva.vertex_credit_fails);
		$display("errors: %0d check, %0d assertion; commands %0d, vertex jobs %0d",
			errors, assert_fails, cmd_seen, vertex_seen);
		if ((errors == 0) && (assert_fails == 0)) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles with %0d commands and %0d vertex jobs missing",
			watchdog_cycles, exp_cmd.size(), exp_vertex.size());
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* verification/vertex_job_control_sva.sv */
// vertex_job_control_sva: reset and credit assertions, bound into vertex_job_control

module vertex_job_control_sva #(
	parameter int CMD_CREDITS    = 2,
	parameter int VERTEX_CREDITS = 4
) (
	input logic clock,
	input logic rstn,
	input logic read_command_valid,
	input logic read_command_credit,
	input logic vertex_valid,
	input logic vertex_credit
);
	timeunit 1ns;
	timeprecision 100ps;

	// items sent and not yet given back as credit
	logic [7:0]  cmd_outstanding;
	logic [7:0]  vertex_outstanding;
	int unsigned reset_fails = 0;
	int unsigned cmd_credit_fails = 0;
	int unsigned vertex_credit_fails = 0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_outstanding    <= '0;
			vertex_outstanding <= '0;
		end else begin
			cmd_outstanding <= cmd_outstanding + 8'(read_command_valid)
				- 8'(read_command_credit);
			vertex_outstanding <= vertex_outstanding + 8'(vertex_valid) - 8'(vertex_credit);
		end
	end

	//////////////////////////////////////////////////
	// assertions
	//////////////////////////////////////////////////

	assert property (@(posedge clock) !rstn |-> (!read_command_valid && !vertex_valid))
		else begin
			$error("valid output high during reset");
			reset_fails++;
		end

	assert property (@(posedge clock) disable iff (!rstn) cmd_outstanding <= 8'(CMD_CREDITS))
		else begin
			$error("more read commands outstanding than command credits");
			cmd_credit_fails++;
		end

	assert property (@(posedge clock) disable iff (!rstn)
		vertex_outstanding <= 8'(VERTEX_CREDITS))
		else begin
			$error("more vertex jobs outstanding than vertex credits");
			vertex_credit_fails++;
		end

endmodule

bind vertex_job_control vertex_job_control_sva #(
	.CMD_CREDITS   (CMD_CREDITS),
	.VERTEX_CREDITS(VERTEX_CREDITS)
) u_sva (
	.clock              (clock),
	.rstn               (rstn),
	.read_command_valid (read_command_valid),
	.read_command_credit(read_command_credit),
	.vertex_valid       (vertex_valid),
	.vertex_credit      (vertex_credit)
);

/* verification/tb_clock_gen.sv */
// tb_clock_gen: free-running testbench clock

module tb_clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clock
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

endmodule

/* rtl/vertex_job_control.sv */
// vertex_job_control: top level joining the read sequencer, unpacker, FIFOs and credit senders

module vertex_job_control #(
	parameter int CMD_FIFO_DEPTH = 4,
	parameter int JOB_FIFO_DEPTH = 16,
	parameter int CMD_CREDITS    = 2,
	parameter int VERTEX_CREDITS = 4
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           job_start,
	input  vertex_job_pkg::job_desc_t      job,
	output logic                           read_command_valid,
	output vertex_job_pkg::read_command_t  read_command,
	input  logic                           read_command_credit,
	input  logic                           read_data_valid,
	input  vertex_job_pkg::read_data_t     read_data,
	output logic                           vertex_valid,
	output vertex_job_pkg::vertex_job_t    vertex,
	input  logic                           vertex_credit
);

	// command path
	logic                                      cmd_push;
	vertex_job_pkg::read_command_t             cmd;
	logic                                      cmd_pop;
	vertex_job_pkg::read_command_t             cmd_head;
	logic                                      cmd_empty;
	logic [$clog2(CMD_FIFO_DEPTH+1)-1:0]       cmd_free;

	// vertex job path
	logic                                      job_push;
	vertex_job_pkg::vertex_job_t               unpack_job;
	logic                                      job_pop;
	vertex_job_pkg::vertex_job_t               job_head;
	logic                                      job_empty;
	logic [$clog2(JOB_FIFO_DEPTH+1)-1:0]       job_free;

	logic                                      chunk_start;
	vertex_job_pkg::chunk_info_t               chunk;
	logic                                      unpack_busy;

	//////////////////////////////////////////////////
	// read side
	//////////////////////////////////////////////////

	vertex_read_request #(
		.CHUNK_ROOM(vertex_job_pkg::CHUNK_VERTICES),
		.JOB_DEPTH (JOB_FIFO_DEPTH),
		.CMD_DEPTH (CMD_FIFO_DEPTH)
	) u_read_request (
		.clock      (clock),
		.rstn       (rstn),
		.job_start  (job_start),
		.job        (job),
		.unpack_busy(unpack_busy),
		.job_free   (job_free),
		.cmd_free   (cmd_free),
		.cmd_push   (cmd_push),
		.cmd        (cmd),
		.chunk_start(chunk_start),
		.chunk      (chunk)
	);

	sync_fifo #(
		.payload_t(vertex_job_pkg::read_command_t),
		.DEPTH    (CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_push),
		.data_in (cmd),
		.pop     (cmd_pop),
		.data_out(cmd_head),
		.empty   (cmd_empty),
		.free    (cmd_free)
	);

	credit_sender #(
		.payload_t  (vertex_job_pkg::read_command_t),
		.MAX_CREDITS(CMD_CREDITS)
	) u_cmd_sender (
		.clock        (clock),
		.rstn         (rstn),
		.empty        (cmd_empty),
		.head         (cmd_head),
		.pop          (cmd_pop),
		.credit_return(read_command_credit),
		.out_valid    (read_command_valid),
		.out_payload  (read_command)
	);

	//////////////////////////////////////////////////
	// vertex side
	//////////////////////////////////////////////////

	vertex_chunk_unpack u_chunk_unpack (
		.clock      (clock),
		.rstn       (rstn),
		.chunk_start(chunk_start),
		.chunk      (chunk),
		.data_valid (read_data_valid),
		.data       (read_data),
		.busy       (unpack_busy),
		.job_push   (job_push),
		.job        (unpack_job)
	);

	sync_fifo #(
		.payload_t(vertex_job_pkg::vertex_job_t),
		.DEPTH    (JOB_FIFO_DEPTH)
	) u_job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_push),
		.data_in (unpack_job),
		.pop     (job_pop),
		.data_out(job_head),
		.empty   (job_empty),
		.free    (job_free)
	);

	credit_sender #(
		.payload_t  (vertex_job_pkg::vertex_job_t),
		.MAX_CREDITS(VERTEX_CREDITS)
	) u_job_sender (
		.clock        (clock),
		.rstn         (rstn),
		.empty        (job_empty),
		.head         (job_head),
		.pop          (job_pop),
		.credit_return(vertex_credit),
		.out_valid    (vertex_valid),
		.out_payload  (vertex)
	);

endmodule

/* rtl/vertex_chunk_unpack.sv */
// vertex_chunk_unpack: captures the three array lines of a chunk and emits one vertex job per cycle

module vertex_chunk_unpack (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         chunk_start,
	input  vertex_job_pkg::chunk_info_t  chunk,
	input  logic                         data_valid,
	input  vertex_job_pkg::read_data_t   data,
	output logic                         busy,
	output logic                         job_push,
	output vertex_job_pkg::vertex_job_t  job
);

	logic [vertex_job_pkg::LINE_BITS-1:0]         degree_line;
	logic [vertex_job_pkg::LINE_BITS-1:0]         edges_line;
	logic [vertex_job_pkg::LINE_BITS-1:0]         parent_line;
	// one flag per array: degree, edge index, parent
	logic [2:0]                                   arrived;
	vertex_job_pkg::chunk_info_t                  info;
	logic [vertex_job_pkg::CHUNK_COUNT_BITS-1:0]  lane_idx;
	logic                                         last_push;

	// beats may come in any order, so wait for all three
	assign job_push = busy && (&arrived);
	assign last_push = job_push && ((lane_idx + 1'b1) == info.count);

	// lane 0 always holds the current vertex
	assign job.id = info.first_id + vertex_job_pkg::COUNT_BITS'(lane_idx);
	assign job.inv_out_degree = degree_line[vertex_job_pkg::VERTEX_BITS-1:0];
	assign job.inv_edges_idx = edges_line[vertex_job_pkg::VERTEX_BITS-1:0];
	assign job.parent = parent_line[vertex_job_pkg::VERTEX_BITS-1:0];

	//////////////////////////////////////////////////
	// chunk control
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy     <= 1'b0;
			arrived  <= '0;
			lane_idx <= '0;
		end else if (chunk_start) begin
			busy     <= 1'b1;
			arrived  <= '0;
			lane_idx <= '0;
		end else if (last_push) begin
			busy    <= 1'b0;
			arrived <= '0;
		end else begin
			if (job_push) begin
				lane_idx <= lane_idx + 1'b1;
			end
			if (data_valid) begin
				case (data.array_sel)
					vertex_job_pkg::ARRAY_INV_OUT_DEGREE: arrived[0] <= 1'b1;
					vertex_job_pkg::ARRAY_INV_EDGES_IDX:  arrived[1] <= 1'b1;
					vertex_job_pkg::ARRAY_PARENT:         arrived[2] <= 1'b1;
					default:                              arrived    <= arrived;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (chunk_start) begin
			info <= chunk;
		end
	end

	//////////////////////////////////////////////////
	// line capture and lane shift
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (job_push) begin
			degree_line <= degree_line >> vertex_job_pkg::VERTEX_BITS;
			edges_line  <= edges_line >> vertex_job_pkg::VERTEX_BITS;
			parent_line <= parent_line >> vertex_job_pkg::VERTEX_BITS;
		end else if (data_valid) begin
			case (data.array_sel)
				vertex_job_pkg::ARRAY_INV_OUT_DEGREE: degree_line <= data.data;
				vertex_job_pkg::ARRAY_INV_EDGES_IDX:  edges_line  <= data.data;
				vertex_job_pkg::ARRAY_PARENT:         parent_line <= data.data;
				default:                              parent_line <= parent_line;
			endcase
		end
	end

endmodule

/* rtl/vertex_read_request.sv */
// vertex_read_request: chunk sequencer issuing the degree, edge-index and parent reads per chunk

module vertex_read_request #(
	parameter int CHUNK_ROOM = 8,
	parameter int JOB_DEPTH  = 16,
	parameter int CMD_DEPTH  = 4
) (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                job_start,
	input  vertex_job_pkg::job_desc_t           job,
	input  logic                                unpack_busy,
	input  logic [$clog2(JOB_DEPTH+1)-1:0]      job_free,
	input  logic [$clog2(CMD_DEPTH+1)-1:0]      cmd_free,
	output logic                                cmd_push,
	output vertex_job_pkg::read_command_t       cmd,
	output logic                                chunk_start,
	output vertex_job_pkg::chunk_info_t         chunk
);

	localparam int JOB_FREE_BITS = $clog2(JOB_DEPTH + 1);
	localparam int CMD_FREE_BITS = $clog2(CMD_DEPTH + 1);

	typedef enum logic [2:0] {
		IDLE,
		WAIT_CHUNK,
		ISSUE_DEGREE,
		ISSUE_EDGES_IDX,
		ISSUE_PARENT
	} state_t;

	state_t                                          state;
	vertex_job_pkg::job_desc_t                       job_q;
	logic [vertex_job_pkg::COUNT_BITS-1:0]           remaining;
	logic [vertex_job_pkg::ADDR_BITS-1:0]            offset;
	logic [vertex_job_pkg::COUNT_BITS-1:0]           next_id;
	logic [vertex_job_pkg::CHUNK_COUNT_BITS-1:0]     chunk_count;
	logic                                            chunk_ok;

	// full line, or whatever is left of the job
	assign chunk_count = (remaining > vertex_job_pkg::COUNT_BITS'(vertex_job_pkg::CHUNK_VERTICES))
		? vertex_job_pkg::CHUNK_COUNT_BITS'(vertex_job_pkg::CHUNK_VERTICES)
		: remaining[vertex_job_pkg::CHUNK_COUNT_BITS-1:0];

	// room for a whole chunk downstream before the first read goes out
	assign chunk_ok = !unpack_busy
		&& (job_free >= JOB_FREE_BITS'(CHUNK_ROOM))
		&& (cmd_free >= CMD_FREE_BITS'(3));

	//////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= IDLE;
			remaining <= '0;
			offset    <= '0;
			next_id   <= '0;
		end else begin
			unique case (state)
				IDLE: begin
					// empty jobs are dropped here
					if (job_start && (job.num_vertices != '0)) begin
						remaining <= job.num_vertices;
						offset    <= '0;
						next_id   <= job.first_id;
						state     <= WAIT_CHUNK;
					end
				end
				WAIT_CHUNK: begin
					if (chunk_ok) begin
						state <= ISSUE_DEGREE;
					end
				end
				ISSUE_DEGREE: begin
					state <= ISSUE_EDGES_IDX;
				end
				ISSUE_EDGES_IDX: begin
					state <= ISSUE_PARENT;
				end
				ISSUE_PARENT: begin
					remaining <= remaining - vertex_job_pkg::COUNT_BITS'(chunk_count);
					offset    <= offset + vertex_job_pkg::ADDR_BITS'(vertex_job_pkg::CHUNK_BYTES);
					next_id   <= next_id + vertex_job_pkg::COUNT_BITS'(chunk_count);
					if (remaining == vertex_job_pkg::COUNT_BITS'(chunk_count)) begin
						state <= IDLE;
					end else begin
						state <= WAIT_CHUNK;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// descriptor is held for the whole job
	always_ff @(posedge clock) begin
		if ((state == IDLE) && job_start) begin
			job_q <= job;
		end
	end

	//////////////////////////////////////////////////
	// command and chunk outputs
	//////////////////////////////////////////////////

	always_comb begin
		cmd_push      = 1'b0;
		cmd.address   = job_q.inv_out_degree_base + offset;
		cmd.array_sel = vertex_job_pkg::ARRAY_INV_OUT_DEGREE;
		cmd.count     = chunk_count;
		case (state)
			ISSUE_DEGREE: begin
				cmd_push = 1'b1;
			end
			ISSUE_EDGES_IDX: begin
				cmd_push      = 1'b1;
				cmd.address   = job_q.inv_edges_idx_base + offset;
				cmd.array_sel = vertex_job_pkg::ARRAY_INV_EDGES_IDX;
			end
			ISSUE_PARENT: begin
				cmd_push      = 1'b1;
				cmd.address   = job_q.parent_base + offset;
				cmd.array_sel = vertex_job_pkg::ARRAY_PARENT;
			end
			default: begin
				cmd_push = 1'b0;
			end
		endcase
	end

	// unpacker learns the chunk along with the first read
	assign chunk_start = (state == ISSUE_DEGREE);
	assign chunk.first_id = next_id;
	assign chunk.count = chunk_count;

endmodule

/* rtl/credit_sender.sv */
// credit_sender: credit counter that drains a FIFO head onto a registered valid/payload output

module credit_sender #(
	parameter type payload_t   = logic [7:0],
	parameter int  MAX_CREDITS = 2
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     empty,
	input  payload_t head,
	output logic     pop,
	input  logic     credit_return,
	output logic     out_valid,
	output payload_t out_payload
);

	localparam int CREDIT_BITS = $clog2(MAX_CREDITS + 1);

	// credits left at the receiver
	logic [CREDIT_BITS-1:0] credits;

	// one item per cycle while credit lasts
	assign pop = !empty && (credits != '0);

	//////////////////////////////////////////////////
	// credit count and valid
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits   <= CREDIT_BITS'(MAX_CREDITS);
			out_valid <= 1'b0;
		end else begin
			// a return and a send in the same cycle cancel out
			credits   <= credits + CREDIT_BITS'(credit_return) - CREDIT_BITS'(pop);
			out_valid <= pop;
		end
	end

	//////////////////////////////////////////////////
	// payload
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (pop) begin
			out_payload <= head;
		end
	end

endmodule

/* rtl/sync_fifo.sv */
// sync_fifo: circular-buffer FIFO of any payload type with empty flag and free-entry count

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  payload_t                     data_in,
	input  logic                         pop,
	output payload_t                     data_out,
	output logic                         empty,
	output logic [$clog2(DEPTH+1)-1:0]   free
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	payload_t            mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] used;
	logic                do_push;
	logic                do_pop;

	// overflow and underflow are ignored
	assign do_push = push && (used != CNT_BITS'(DEPTH));
	assign do_pop = pop && (used != '0);

	assign empty = (used == '0);
	assign free = CNT_BITS'(DEPTH) - used;
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// pointers wrap at DEPTH, so depth need not be a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			used <= used + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
		end
	end

endmodule

/* rtl/vertex_job_pkg.sv */
// widths, array selector, job descriptor, read command/data, chunk info and vertex job types

package vertex_job_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	// one vertex field in a data line
	localparam int unsigned VERTEX_BITS = 32;
	localparam int unsigned ADDR_BITS = 48;
	// vertex counts and ids
	localparam int unsigned COUNT_BITS = 32;

	// vertices carried by one data line
	localparam int unsigned CHUNK_VERTICES = 8;
	localparam int unsigned LINE_BITS = CHUNK_VERTICES * VERTEX_BITS;
	// address step per chunk, 4 bytes per field
	localparam int unsigned CHUNK_BYTES = CHUNK_VERTICES * 4;
	// holds 0 .. CHUNK_VERTICES
	localparam int unsigned CHUNK_COUNT_BITS = $clog2(CHUNK_VERTICES) + 1;

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ARRAY_INV_OUT_DEGREE = 2'd0,
		ARRAY_INV_EDGES_IDX  = 2'd1,
		ARRAY_PARENT         = 2'd2
	} array_sel_t;

	typedef struct packed {
		logic [ADDR_BITS-1:0]  inv_out_degree_base;
		logic [ADDR_BITS-1:0]  inv_edges_idx_base;
		logic [ADDR_BITS-1:0]  parent_base;
		logic [COUNT_BITS-1:0] num_vertices;
		logic [COUNT_BITS-1:0] first_id;
	} job_desc_t;

	// count is the number of vertices in this chunk
	typedef struct packed {
		logic [ADDR_BITS-1:0]        address;
		array_sel_t                  array_sel;
		logic [CHUNK_COUNT_BITS-1:0] count;
	} read_command_t;

	// lane 0 sits in the low VERTEX_BITS bits
	typedef struct packed {
		array_sel_t           array_sel;
		logic [LINE_BITS-1:0] data;
	} read_data_t;

	typedef struct packed {
		logic [COUNT_BITS-1:0]       first_id;
		logic [CHUNK_COUNT_BITS-1:0] count;
	} chunk_info_t;

	typedef struct packed {
		logic [COUNT_BITS-1:0]  id;
		logic [VERTEX_BITS-1:0] inv_out_degree;
		logic [VERTEX_BITS-1:0] inv_edges_idx;
		logic [VERTEX_BITS-1:0] parent;
	} vertex_job_t;

endpackage
